// ==== Makefile ====
# Verilator build and run of the core testbench

SIM  := obj_dir/Vcore_tb
SRCS := $(wildcard verilog/*.sv tests/*.sv)

.PHONY: all run clean

all: run

$(SIM): core_top.f $(SRCS)
	verilator --binary --timing --top-module core_tb -f core_top.f -o Vcore_tb

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== core_top.f ====
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/inst_decoder.sv
verilog/execute_stage.sv
verilog/core_sequencer.sv
verilog/core_top.sv
tests/core_tb_assertions.sv
tests/core_tb.sv

// ==== tests/core_tb.sv ====
/* core_tb
   runs a generated rv32i program on the core against a reference model */
`timescale 1ns/100ps
`default_nettype none

module core_tb;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    logic               clk;
    logic               reset;
    core_pkg::apb_req_t apb_req;
    core_pkg::apb_rsp_t apb_rsp;
    logic               retire;
    logic               halted;

    logic [31:0] mem [256];      // bus memory
    logic [31:0] ref_mem [256];  // reference copy
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic        ref_halted;
    logic [31:0] lfsr_state;
    int          prog_ptr, store_off, ref_count, retire_count;
    int          cycle_count, cycle_limit;
    logic        expect_mem;
    core_pkg::apb_req_t req_seen;
    logic        ready_seen;
    logic [1:0]  waits_left;
    logic [31:0] xfer_addr;

    core_top DUT (
        .clk    (clk),
        .reset  (reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .retire (retire),
        .halted (halted)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state); // one step per bit
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[prog_ptr] = w;
        prog_ptr++;
    endtask

    task automatic store_reg(input logic [4:0] rs);
        logic [11:0] off;
        off = 12'(store_off);
        emit({off[11:5], rs, 5'd31, 3'b010, off[4:0], op_store}); // sw rs, off(x31)
        store_off += 4;
    endtask

    task automatic build_program();
        logic [2:0] f3_tab [10];
        logic       alt_tab [10];
        logic [2:0] br_tab [6];
        logic [4:0] ra_tab [4];
        logic [4:0] rb_tab [4];
        f3_tab  = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        alt_tab = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        br_tab  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        ra_tab  = '{5'd1, 5'd1, 5'd12, 5'd13};
        rb_tab  = '{5'd2, 5'd1, 5'd13, 5'd12};
        prog_ptr  = 0;
        store_off = 0;
        emit(enc_i(12'h300, 5'd0, 3'd0, 5'd31, op_imm)); // data base
        emit(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd1, op_imm));
        emit(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, 5'd2, op_imm));
        emit({20'(rand_bits(20)), 5'd3, op_lui});
        emit(enc_i(12'(rand_bits(12)), 5'd3, 3'd0, 5'd3, op_imm));
        emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd12, op_imm)); // -1
        emit(enc_i(12'h001, 5'd0, 3'd0, 5'd13, op_imm));
        for (int i = 0; i < 10; i++) begin
            emit(enc_r(alt_tab[i] ? 7'h20 : 7'h00, 5'd2, 5'd3, f3_tab[i], 5'd4));
            store_reg(5'd4);
        end
        foreach (f3_tab[i]) begin
            if (i == 1) continue; // no subi
            if (f3_tab[i] == 3'd1 || f3_tab[i] == 3'd5) begin
                emit(enc_i({alt_tab[i] ? 7'h20 : 7'h00, 5'(rand_bits(5))}, 5'd3,
                           f3_tab[i], 5'd4, op_imm));
            end else begin
                emit(enc_i(12'(rand_bits(12)), 5'd3, f3_tab[i], 5'd4, op_imm));
            end
            store_reg(5'd4);
        end
        emit({20'(rand_bits(20)), 5'd5, op_lui});
        store_reg(5'd5);
        emit({20'(rand_bits(20)), 5'd5, op_auipc});
        store_reg(5'd5);
        emit(enc_i(12'd5, 5'd1, 3'd0, 5'd0, op_imm)); // write to x0 is dropped
        store_reg(5'd0);
        // each pair adds its own weight when the branch falls through
        for (int c = 0; c < 6; c++) begin
            emit(enc_i(12'd0, 5'd0, 3'd0, 5'd9, op_imm));
            for (int p = 0; p < 4; p++) begin
                emit(enc_b(13'd8, rb_tab[p], ra_tab[p], br_tab[c]));
                emit(enc_i(12'(1 << p), 5'd9, 3'd0, 5'd9, op_imm));
            end
            store_reg(5'd9);
        end
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd6, op_imm)); // backward loop
        emit(enc_i(12'hfff, 5'd6, 3'd0, 5'd6, op_imm));
        emit(enc_b(13'h1ffc, 5'd0, 5'd6, 3'd1));
        store_reg(5'd6);
        emit(enc_j(21'd12, 5'd14));
        emit(enc_i(12'd100, 5'd9, 3'd0, 5'd9, op_imm));
        emit(enc_i(12'd100, 5'd9, 3'd0, 5'd9, op_imm));
        store_reg(5'd14);
        store_reg(5'd9);
        emit({20'd0, 5'd15, op_auipc});
        emit(enc_i(12'd17, 5'd15, 3'd0, 5'd16, op_jalr)); // odd target, lands at +16
        emit(enc_i(12'd7, 5'd9, 3'd0, 5'd9, op_imm));
        emit(enc_i(12'd7, 5'd9, 3'd0, 5'd9, op_imm));
        store_reg(5'd16);
        store_reg(5'd9);
        emit(enc_i(12'd0, 5'd31, 3'b010, 5'd17, op_load));
        emit(enc_i(12'd4, 5'd31, 3'b010, 5'd18, op_load));
        emit(enc_r(7'h00, 5'd18, 5'd17, 3'd0, 5'd19));
        store_reg(5'd17);
        store_reg(5'd19);
        emit(32'h00100073); // ebreak
    endtask

    // reference model
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // address of the current load or store
    function automatic logic [31:0] ref_addr();
        logic [31:0] inst;
        inst = ref_mem[ref_pc[9:2]];
        if (inst[6:0] == op_store) begin
            return ref_regs[inst[19:15]] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        end
        return ref_regs[inst[19:15]] + {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic void ref_step();
        logic [31:0] inst, a, b, immi, val, npc;
        logic        wr;
        inst = ref_mem[ref_pc[9:2]];
        a    = ref_regs[inst[19:15]];
        b    = ref_regs[inst[24:20]];
        immi = {{20{inst[31]}}, inst[31:20]};
        npc  = ref_pc + 32'd4;
        val  = '0;
        wr   = 1'b1;
        case (inst[6:0])
            op_reg:   val = ref_alu(inst[14:12], inst[30], a, b);
            op_imm:   val = ref_alu(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, immi);
            op_load:  val = ref_mem[ref_addr() >> 2];
            op_lui:   val = {inst[31:12], 12'b0};
            op_auipc: val = ref_pc + {inst[31:12], 12'b0};
            op_jalr: begin
                val = npc;
                npc = (a + immi) & ~32'd1;
            end
            7'b1101111: begin
                val = npc;
                npc = ref_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
            end
            op_store: begin
                wr = 1'b0;
                ref_mem[ref_addr() >> 2] = b;
            end
            op_branch: begin
                wr = 1'b0;
                if (ref_taken(inst[14:12], a, b)) begin
                    npc = ref_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                    inst[11:8], 1'b0};
                end
            end
            default: begin
                wr = 1'b0;
                if (inst == 32'h00100073) ref_halted = 1'b1;
            end
        endcase
        if (wr && inst[11:7] != 5'd0) ref_regs[inst[11:7]] = val;
        ref_pc = npc;
    endfunction

    task automatic reset_reference();
        foreach (ref_regs[i]) ref_regs[i] = '0;
        foreach (mem[i]) ref_mem[i] = mem[i];
        ref_pc     = '0;
        ref_halted = 1'b0;
    endtask

    // APB slave with 0 to 2 random wait states
    always @(posedge clk) begin
        req_seen   = apb_req;
        ready_seen = apb_rsp.pready;
        #1;
        if (reset) begin
            apb_rsp = '0;
        end else if (req_seen.psel && req_seen.penable && ready_seen) begin
            if (req_seen.pwrite) mem[req_seen.paddr[9:2]] = req_seen.pwdata;
            apb_rsp.pready = 1'b0;
        end else if (req_seen.psel && !req_seen.penable) begin
            xfer_addr  = req_seen.paddr;
            waits_left = 2'(rand_bits(2));
            if (waits_left == 2'd3) waits_left = 2'd2;
            apb_rsp.pready = (waits_left == 2'd0);
            apb_rsp.prdata = mem[xfer_addr[9:2]];
        end else if (req_seen.psel && req_seen.penable) begin
            waits_left     = waits_left - 2'd1;
            apb_rsp.pready = (waits_left == 2'd0);
        end
    end

    // compare bus traffic against the reference
    always @(posedge clk) begin
        if (!reset) begin
            if (apb_req.psel && !apb_req.penable) begin
                if (expect_mem) begin
                    check("mem address", ref_addr(), apb_req.paddr);
                    check("mem write flag", 32'(ref_mem[ref_pc[9:2]][6:0] == op_store),
                          32'(apb_req.pwrite));
                    expect_mem = 1'b0;
                end else begin
                    check("fetch address", ref_pc, apb_req.paddr);
                    check("fetch write flag", 32'd0, 32'(apb_req.pwrite));
                    expect_mem = ref_mem[ref_pc[9:2]][6:0] == op_load ||
                                 ref_mem[ref_pc[9:2]][6:0] == op_store;
                end
            end
            if (apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
                check("store address", ref_addr(), apb_req.paddr);
                check("store data", ref_regs[ref_mem[ref_pc[9:2]][24:20]], apb_req.pwdata);
            end
            if (retire) begin
                ref_step();
                retire_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: core did not halt within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        apb_rsp      = '0;
        lfsr_state   = 32'h11bc;
        retire_count = 0;
        cycle_count  = 0;
        cycle_limit  = 0;
        expect_mem   = 1'b0;
        foreach (mem[i]) mem[i] = 32'(i) * 32'h9e3779b9 ^ 32'h5a5a0000; // unused area
        build_program();
        reset_reference();
        ref_count = 0;
        while (!ref_halted && ref_count < 10000) begin
            ref_step();
            ref_count++;
        end
        if (!ref_halted) begin
            $display("reference model never reached ebreak");
            $display("TEST FAILED");
            $fatal(1, "bad program");
        end
        reset_reference();
        cycle_limit = ref_count * (7 + 4) + 100;
        repeat (5) @(posedge clk);
        check("psel in reset", 32'd0, 32'(apb_req.psel));
        check("penable in reset", 32'd0, 32'(apb_req.penable));
        check("retire in reset", 32'd0, 32'(retire));
        check("halted in reset", 32'd0, 32'(halted));
        #1 reset = 1'b0;
        while (!halted) @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check("psel after halt", 32'd0, 32'(apb_req.psel));
        end
        check("retire count", 32'(ref_count), 32'(retire_count));
        check("halted stays high", 32'd1, 32'(halted));
        if (DUT.u_assertions.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/core_tb_assertions.sv ====
/* core_tb_assertions
   APB protocol and halt checks bound into the core top level */
`timescale 1ns/100ps
`default_nettype none

module core_tb_assertions (
    input logic               clk,
    input logic               reset,
    input core_pkg::apb_req_t apb_req,
    input core_pkg::apb_rsp_t apb_rsp,
    input logic               halted
);
    int fail_count = 0; // assertion failures so far

    // request held through wait states
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
        else begin
            fail_count++;
            $error("APB request changed during a wait state");
        end

    // access phase only right after a setup cycle
    enable_needs_sel: assert property (@(posedge clk) disable iff (reset)
        $rose(apb_req.penable) |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
        else begin
            fail_count++;
            $error("penable rose without a preceding setup cycle");
        end

    no_bus_after_halt: assert property (@(posedge clk) disable iff (reset)
        halted |-> !apb_req.psel)
        else begin
            fail_count++;
            $error("APB transfer started after halt");
        end

endmodule

bind core_top core_tb_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .apb_req(apb_req),
    .apb_rsp(apb_rsp),
    .halted (halted)
);

`default_nettype wire

// ==== verilog/core_pkg.sv ====
/* core_pkg
   shared widths, instruction formats, control word and APB types of the rv32i core */
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_addr_t  rd;
        opcode_t    opcode;
    } j_fmt_t;

    // one instruction word, viewed through each encoding format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_link, // pc + 4
        wb_load
    } wb_sel_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    a_is_pc;
        logic    a_is_zero;
        logic    b_is_imm;
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_sel_t wb_sel;
        logic    halt; // ebreak
    } ctrl_t;

    typedef struct packed {
        word_t paddr;
        word_t pwdata;
        logic  pwrite;
        logic  psel;
        logic  penable;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/core_sequencer.sv ====
/* core_sequencer
   pc, instruction register and the APB fetch/load/store state machine */
`timescale 1ns/100ps
`default_nettype none

module core_sequencer #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::ctrl_t     ctrl,
    input  core_pkg::word_t     next_pc,
    input  core_pkg::word_t     mem_addr,
    input  core_pkg::word_t     wb_data,
    input  core_pkg::word_t     store_data,
    input  core_pkg::apb_rsp_t  apb_rsp,
    output core_pkg::apb_req_t  apb_req,
    output core_pkg::inst_u     inst,
    output core_pkg::word_t     pc,
    output logic                rf_we,
    output core_pkg::reg_addr_t rf_waddr,
    output core_pkg::word_t     rf_wdata,
    output logic                retire,
    output logic                halted
);
    typedef enum logic [2:0] {
        idle,         // bus gap between transfers
        fetch_setup,
        fetch_access,
        exec,
        mem_setup,
        mem_access,
        halt
    } state_t;

    state_t state, state_next;
    logic   is_mem;
    logic   fetch_phase, mem_phase;
    logic   commit;

    assign is_mem      = ctrl.mem_read | ctrl.mem_write;
    assign fetch_phase = (state == fetch_setup) || (state == fetch_access);
    assign mem_phase   = (state == mem_setup) || (state == mem_access);

    // register write and pc update happen together
    assign commit = ((state == exec) && !is_mem) ||
                    ((state == mem_access) && apb_rsp.pready);

    always_comb begin
        state_next = state;
        unique case (state)
            idle:         state_next = fetch_setup;
            fetch_setup:  state_next = fetch_access;
            fetch_access: if (apb_rsp.pready) state_next = exec;
            exec: begin
                if (is_mem) begin
                    state_next = mem_setup;
                end else if (ctrl.halt) begin
                    state_next = halt;
                end else begin
                    state_next = fetch_setup; // psel already low in exec
                end
            end
            mem_setup:    state_next = mem_access;
            mem_access:   if (apb_rsp.pready) state_next = idle;
            halt:         state_next = halt;
            default:      state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= idle;
            pc     <= reset_pc;
            inst   <= '0; // decodes as a nop
            halted <= 1'b0;
        end else begin
            state <= state_next;
            if (commit) begin
                pc <= next_pc;
            end
            if ((state == fetch_access) && apb_rsp.pready) begin
                inst <= core_pkg::inst_u'(apb_rsp.prdata);
            end
            if (commit && ctrl.halt) begin
                halted <= 1'b1;
            end
        end
    end

    // bus request straight from state, stable through wait states
    always_comb begin
        apb_req.psel    = fetch_phase | mem_phase;
        apb_req.penable = (state == fetch_access) || (state == mem_access);
        apb_req.pwrite  = mem_phase & ctrl.mem_write;
        apb_req.paddr   = mem_phase ? mem_addr : pc;
        apb_req.pwdata  = (mem_phase && ctrl.mem_write) ? store_data : '0;
    end

    assign rf_waddr = inst.r_fmt.rd;
    assign rf_we    = commit && ctrl.reg_write && (rf_waddr != '0); // x0 never written
    assign rf_wdata = (ctrl.wb_sel == core_pkg::wb_load) ? apb_rsp.prdata : wb_data;
    assign retire   = commit;

endmodule

`default_nettype wire

// ==== verilog/core_top.sv ====
/* core_top
   multicycle rv32i core with one APB master port for instructions and data */
`timescale 1ns/100ps
`default_nettype none

module core_top #(
    parameter core_pkg::word_t reset_pc = '0
) (
    input  logic               clk,
    input  logic               reset,
    output core_pkg::apb_req_t apb_req,
    input  core_pkg::apb_rsp_t apb_rsp,
    output logic               retire,
    output logic               halted
);
    core_pkg::inst_u     inst;
    core_pkg::ctrl_t     ctrl;
    core_pkg::word_t     imm, pc;
    core_pkg::word_t     rs1_data, rs2_data;
    core_pkg::word_t     next_pc, mem_addr, wb_data, store_data;
    logic                rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::word_t     rf_wdata;

    core_sequencer #(
        .reset_pc(reset_pc)
    ) u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .next_pc   (next_pc),
        .mem_addr  (mem_addr),
        .wb_data   (wb_data),
        .store_data(store_data),
        .apb_rsp   (apb_rsp),
        .apb_req   (apb_req),
        .inst      (inst),
        .pc        (pc),
        .rf_we     (rf_we),
        .rf_waddr  (rf_waddr),
        .rf_wdata  (rf_wdata),
        .retire    (retire),
        .halted    (halted)
    );

    inst_decoder u_decoder (
        .inst(inst),
        .imm (imm),
        .ctrl(ctrl)
    );

    execute_stage u_execute (
        .ctrl      (ctrl),
        .inst      (inst),
        .pc        (pc),
        .imm       (imm),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .next_pc   (next_pc),
        .mem_addr  (mem_addr),
        .wb_data   (wb_data),
        .store_data(store_data)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .reset (reset),
        .we    (rf_we),
        .waddr (rf_waddr),
        .raddr1(inst.r_fmt.rs1),
        .raddr2(inst.r_fmt.rs2),
        .wdata (rf_wdata),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
/* execute_stage
   alu, branch compare, next pc and write-back data of the current instruction */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  core_pkg::ctrl_t ctrl,
    input  core_pkg::inst_u inst,
    input  core_pkg::word_t pc,
    input  core_pkg::word_t imm,
    input  core_pkg::word_t rs1_data,
    input  core_pkg::word_t rs2_data,
    output core_pkg::word_t next_pc,
    output core_pkg::word_t mem_addr,
    output core_pkg::word_t wb_data,
    output core_pkg::word_t store_data
);
    core_pkg::word_t alu_a, alu_b, alu_result;
    core_pkg::word_t pc_plus4, target;
    logic [4:0]      shamt;
    logic            lt_s, lt_u;
    logic            cond, taken;

    always_comb begin
        if (ctrl.a_is_zero) begin
            alu_a = '0; // lui
        end else if (ctrl.a_is_pc) begin
            alu_a = pc;
        end else begin
            alu_a = rs1_data;
        end
    end

    assign alu_b = ctrl.b_is_imm ? imm : rs2_data;
    assign shamt = alu_b[4:0];

    always_comb begin
        unique case (ctrl.alu_op)
            core_pkg::alu_add:  alu_result = alu_a + alu_b;
            core_pkg::alu_sub:  alu_result = alu_a - alu_b;
            core_pkg::alu_sll:  alu_result = alu_a << shamt;
            core_pkg::alu_slt:  alu_result = {{(core_pkg::xlen-1){1'b0}},
                                              $signed(alu_a) < $signed(alu_b)};
            core_pkg::alu_sltu: alu_result = {{(core_pkg::xlen-1){1'b0}}, alu_a < alu_b};
            core_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            core_pkg::alu_srl:  alu_result = alu_a >> shamt;
            core_pkg::alu_sra:  alu_result = $signed(alu_a) >>> shamt;
            core_pkg::alu_or:   alu_result = alu_a | alu_b;
            core_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:            alu_result = '0;
        endcase
    end

    // branch compare always on the two registers
    assign lt_s = $signed(rs1_data) < $signed(rs2_data);
    assign lt_u = rs1_data < rs2_data;

    always_comb begin
        unique case (inst.b_fmt.funct3)
            3'b000:  cond = (rs1_data == rs2_data); // beq
            3'b001:  cond = (rs1_data != rs2_data); // bne
            3'b100:  cond = lt_s;
            3'b101:  cond = !lt_s;
            3'b110:  cond = lt_u;
            3'b111:  cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign taken    = ctrl.is_jal | ctrl.is_jalr | (ctrl.is_branch & cond);
    assign pc_plus4 = pc + 32'd4;
    assign target   = ctrl.is_jalr ? {alu_result[31:1], 1'b0} : alu_result;
    assign next_pc  = taken ? target : pc_plus4;

    // load data is picked later in the sequencer
    assign wb_data    = (ctrl.wb_sel == core_pkg::wb_link) ? pc_plus4 : alu_result;
    assign mem_addr   = alu_result;
    assign store_data = rs2_data;

endmodule

`default_nettype wire

// ==== verilog/inst_decoder.sv ====
/* inst_decoder
   builds the immediate and the control word from one instruction */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  core_pkg::inst_u inst,
    output core_pkg::word_t imm,
    output core_pkg::ctrl_t ctrl
);
    core_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    core_pkg::alu_op_t arith_op;
    logic              funct7_alt;

    assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    assign funct7_alt = inst.r_fmt.funct7[5]; // sub and sra

    // shared by op and op_imm
    always_comb begin
        arith_op = core_pkg::alu_add;
        unique case (inst.r_fmt.funct3)
            3'b000: begin
                if ((inst.r_fmt.opcode == core_pkg::opc_op) && funct7_alt) begin
                    arith_op = core_pkg::alu_sub; // no subi
                end
            end
            3'b001: arith_op = core_pkg::alu_sll;
            3'b010: arith_op = core_pkg::alu_slt;
            3'b011: arith_op = core_pkg::alu_sltu;
            3'b100: arith_op = core_pkg::alu_xor;
            3'b101: arith_op = funct7_alt ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110: arith_op = core_pkg::alu_or;
            3'b111: arith_op = core_pkg::alu_and;
        endcase
    end

    always_comb begin
        unique case (inst.r_fmt.opcode)
            core_pkg::opc_op_imm, core_pkg::opc_load,
            core_pkg::opc_jalr, core_pkg::opc_system: imm = imm_i;
            core_pkg::opc_store:                      imm = imm_s;
            core_pkg::opc_branch:                     imm = imm_b;
            core_pkg::opc_lui, core_pkg::opc_auipc:   imm = imm_u;
            core_pkg::opc_jal:                        imm = imm_j;
            default:                                  imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0; // unknown opcode falls through as a nop
        unique case (inst.r_fmt.opcode)
            core_pkg::opc_op: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::opc_op_imm: begin
                ctrl.alu_op    = arith_op;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::opc_load: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::wb_load;
            end
            core_pkg::opc_store: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            core_pkg::opc_branch: begin
                ctrl.a_is_pc   = 1'b1; // alu gives the target
                ctrl.b_is_imm  = 1'b1;
                ctrl.is_branch = 1'b1;
            end
            core_pkg::opc_jal: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::wb_link;
            end
            core_pkg::opc_jalr: begin
                ctrl.b_is_imm  = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = core_pkg::wb_link;
            end
            core_pkg::opc_lui: begin
                ctrl.a_is_zero = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::opc_auipc: begin
                ctrl.a_is_pc   = 1'b1;
                ctrl.b_is_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            core_pkg::opc_system: begin
                // only ebreak is kept
                ctrl.halt = (inst.i_fmt.funct3 == 3'b000) && (inst.i_fmt.imm == 12'h001);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
/* reg_file
   32 general purpose registers, two combinational reads and one write port */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    input  core_pkg::word_t     wdata,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2
);
    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire
